/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_pkg.sv
      - verilog/fetch_stage.sv
      - verilog/regfile.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/memory_stage.sv
      - verilog/mips_top.sv
  - target: test
    include_dirs:
      - verilog
      - verification
    files:
      - verification/mips_tb.sv

/* project.f */
+incdir+verilog
+incdir+verification
verilog/mips_pkg.sv
verilog/fetch_stage.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/mips_top.sv
verification/mips_tb.sv

/* verification/mips_iss_model.svh */
`ifndef MIPS_ISS_MODEL_SVH
`define MIPS_ISS_MODEL_SVH

// architectural run of imem, fills the expected write and store queues
task automatic run_iss();
    logic [31:0] regs [32];
    logic [31:0] w, a, b, res, addr, sext, zext;
    logic [4:0]  rs, rt, rd, dst;
    logic        wr, taken;
    int          pc, npc, target, steps, kind;
    for (int i = 0; i < 32; i++) begin
        regs[i] = 32'd0;
    end
    for (int i = 0; i < 64; i++) begin
        iss_dmem[i] = fill_word(i * 4);
    end
    pc    = 0;
    npc   = 1;
    steps = 0;
    // stop at the final self loop
    while (pc != N_INST - 2 && steps < 4 * N_INST) begin
        w      = imem[pc];
        rs     = w[25:21];
        rt     = w[20:16];
        rd     = w[15:11];
        a      = regs[rs];
        b      = regs[rt];
        sext   = {{16{w[15]}}, w[15:0]};
        zext   = {16'd0, w[15:0]};
        wr     = 1'b1;
        dst    = rt;
        res    = 32'd0;
        kind   = 1;
        taken  = 1'b0;
        target = pc + 1 + int'($signed(w[15:0]));
        case (w[31:26])
            `MIPS_OP_SPECIAL: begin
                dst = rd;
                case (w[5:0])
                    `MIPS_FUNCT_ADDU: res = a + b;
                    `MIPS_FUNCT_SUBU: res = a - b;
                    `MIPS_FUNCT_AND:  res = a & b;
                    `MIPS_FUNCT_OR:   res = a | b;
                    `MIPS_FUNCT_XOR:  res = a ^ b;
                    `MIPS_FUNCT_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                    `MIPS_FUNCT_SLL:  res = b << w[10:6];
                    default:          wr = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: res = a + sext;
            `MIPS_OP_ORI:   res = a | zext;
            `MIPS_OP_LUI:   res = {w[15:0], 16'd0};
            `MIPS_OP_LW: begin
                addr = a + sext;
                res  = iss_dmem[addr[7:2]];
                kind = 2;
            end
            `MIPS_OP_SW: begin
                wr   = 1'b0;
                addr = a + sext;
                iss_dmem[addr[7:2]] = b;
                st_addr.push_back(addr);
                st_data.push_back(b);
            end
            `MIPS_OP_BEQ: begin
                wr    = 1'b0;
                taken = (a == b);
            end
            `MIPS_OP_BNE: begin
                wr    = 1'b0;
                taken = (a != b);
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            regs[dst] = res;
            exp_pc.push_back(`MIPS_RESET_PC + pc * 4);
            exp_num.push_back(dst);
            exp_data.push_back(res);
            exp_kind.push_back(kind);
        end
        // delay slot runs before the redirect
        pc    = npc;
        npc   = taken ? target : npc + 1;
        steps = steps + 1;
    end
endtask

`endif

/* verification/mips_tb.sv */
`include "mips_consts.svh"

module mips_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INST = 200;

    logic        clock, reset, data_stall;
    logic [31:0] inst_rdata, data_rdata;
    logic [31:0] inst_addr, data_addr, data_wdata, wb_pc, wb_data;
    logic        inst_ren, data_ren;
    logic [3:0]  data_wen, wb_wen;
    logic [4:0]  wb_num;

    logic [31:0] imem [N_INST];
    logic [31:0] dmem [64];
    logic [31:0] iss_dmem [64];
    logic [31:0] exp_pc[$], exp_data[$], st_addr[$], st_data[$];
    logic [4:0]  exp_num[$];
    int          exp_kind[$];
    logic [31:0] rng_state;
    logic [31:0] fetch_addr;
    logic        fetch_ren, first_fetch_seen, retired_any;
    int          errors [6];
    string       test_names [6] = '{"reset idle", "alu results", "loads and stores",
                                    "branch order", "back-pressure", "completion"};

    mips_top dut0 (
        .clock_i(clock), .reset_i(reset),
        .inst_sram_addr_o(inst_addr), .inst_sram_ren_o(inst_ren),
        .inst_sram_rdata_i(inst_rdata),
        .data_sram_ren_o(data_ren), .data_sram_wen_o(data_wen),
        .data_sram_addr_o(data_addr), .data_sram_wdata_o(data_wdata),
        .data_sram_rdata_i(data_rdata), .data_stall_i(data_stall),
        .debug_wb_pc_o(wb_pc), .debug_wb_wen_o(wb_wen),
        .debug_wb_num_o(wb_num), .debug_wb_data_o(wb_data)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ (addr << 16) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `MIPS_RESET_PC) >> 2;
        return (idx < N_INST) ? imem[idx] : 32'd0;
    endfunction

    task automatic check(input int test, input string name, input logic [31:0] got,
                         input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors[test]++;
        end
    endtask

    `include "mips_iss_model.svh"

    // registers r0..r7 only, so dependencies are dense
    task automatic build_program();
        logic [31:0] r;
        logic [4:0]  rs, rt, rd;
        logic        prev_branch;
        int          kind;
        logic [5:0]  functs [6] = '{`MIPS_FUNCT_ADDU, `MIPS_FUNCT_SUBU, `MIPS_FUNCT_AND,
                                    `MIPS_FUNCT_OR, `MIPS_FUNCT_XOR, `MIPS_FUNCT_SLT};
        prev_branch = 1'b0;
        for (int i = 0; i < N_INST - 2; i++) begin
            r    = next_rand();
            rs   = {2'd0, r[2:0]};
            rt   = {2'd0, r[5:3]};
            rd   = {2'd0, r[8:6]};
            kind = (next_rand() >> 16) % 14;
            if (i < 2) kind = kind % 10;
            if ((kind >= 12) && (prev_branch || i > N_INST - 8)) kind = kind - 5;
            case (kind)
                0, 1, 2, 3, 4, 5: imem[i] = {6'd0, rs, rt, rd, 5'd0, functs[kind]};
                6: imem[i] = {6'd0, 5'd0, rt, rd, r[13:9], `MIPS_FUNCT_SLL};
                7: imem[i] = {`MIPS_OP_ADDIU, rs, rt, r[31:16]};
                8: imem[i] = {`MIPS_OP_ORI, rs, rt, r[31:16]};
                9: imem[i] = {`MIPS_OP_LUI, 5'd0, rt, r[31:16]};
                10: imem[i] = {`MIPS_OP_LW, 5'd0, rt, 8'd0, r[21:16], 2'b00};
                11: imem[i] = {`MIPS_OP_SW, 5'd0, rt, 8'd0, r[21:16], 2'b00};
                12: imem[i] = {`MIPS_OP_BEQ, rs, rt, 13'd0, {1'b0, r[17:16]} + 3'd1};
                default: imem[i] = {`MIPS_OP_BNE, rs, rt, 13'd0, {1'b0, r[17:16]} + 3'd1};
            endcase
            prev_branch = (kind >= 12);
        end
        imem[N_INST - 2] = {`MIPS_OP_BEQ, 5'd0, 5'd0, 16'hffff};
        imem[N_INST - 1] = 32'd0;
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // instruction sram answers one cycle late
    always @(negedge clock) begin
        fetch_addr <= inst_addr;
        fetch_ren  <= inst_ren & ~reset;
    end

    always @(posedge clock) begin
        #1;
        if (fetch_ren) inst_rdata = fetch_word(fetch_addr);
        if (!reset) data_stall = ((next_rand() >> 28) < 4);
    end

    // read data only valid while ren is high
    assign data_rdata = data_ren ? dmem[data_addr[7:2]] : 32'hx;

    // outputs are stable at the falling edge
    always @(negedge clock) begin
        if (!reset && inst_ren && !first_fetch_seen) begin
            check(0, "inst_sram_addr_o", inst_addr, `MIPS_RESET_PC);
            first_fetch_seen = 1'b1;
        end
        if (!reset && !retired_any) begin
            check(0, "data_sram_wen_o", {28'd0, data_wen}, 32'd0);
            check(0, "data_sram_ren_o", {31'd0, data_ren}, 32'd0);
        end
        if (wb_wen != 4'b0000) begin
            retired_any = 1'b1;
            if (exp_pc.size() == 0) begin
                $display("extra register write to r%0d at %0t", wb_num, $time);
                errors[5]++;
            end else begin
                check(3, "debug_wb_pc_o", wb_pc, exp_pc.pop_front());
                check(exp_kind.pop_front(), "debug_wb_num_o", {27'd0, wb_num},
                      {27'd0, exp_num.pop_front()});
                check(1, "debug_wb_data_o", wb_data, exp_data.pop_front());
                check(1, "debug_wb_wen_o", {28'd0, wb_wen}, 32'hf);
            end
        end
        if (data_wen != 4'b0000) begin
            if (st_addr.size() == 0) begin
                $display("store seen with no store left in the model at %0t", $time);
                errors[4]++;
            end else begin
                check(2, "data_sram_wen_o", {28'd0, data_wen}, 32'hf);
                check(2, "data_sram_addr_o", data_addr, st_addr.pop_front());
                check(2, "data_sram_wdata_o", data_wdata, st_data.pop_front());
            end
            dmem[data_addr[7:2]] = data_wdata;
        end
    end

    initial begin
        #(N_INST * 20 * 10);
        $display("run timed out with %0d register writes still expected", exp_pc.size());
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int total;
        int failed;
        reset            = 1'b1;
        data_stall       = 1'b0;
        inst_rdata       = 32'd0;
        first_fetch_seen = 1'b0;
        retired_any      = 1'b0;
        rng_state        = 32'h2046;
        for (int i = 0; i < 6; i++) errors[i] = 0;
        for (int i = 0; i < 64; i++) dmem[i] = fill_word(i * 4);
        build_program();
        run_iss();
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
        while (exp_pc.size() != 0 || st_addr.size() != 0) @(posedge clock);
        // the final loop must stay quiet
        repeat (20) @(posedge clock);
        failed = 0;
        total  = 0;
        for (int i = 0; i < 6; i++) begin
            $display("test %s: %0d errors", test_names[i], errors[i]);
            total += errors[i];
            if (errors[i] != 0) failed++;
        end
        $display("tests run 6, failed %0d, errors %0d", failed, total);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog/decode_stage.sv */
`include "mips_consts.svh"

module decode_stage
    import mips_pkg::*;
(
    input  logic        clock_i,
    input  logic        reset_i,
    input  logic        freeze_i,
    input  logic [31:0] id_pc_i,
    input  mips_inst_u  id_inst_i,
    input  logic        id_valid_i,
    input  logic [31:0] rs_data_i,
    input  logic [31:0] rt_data_i,
    input  logic        ex_wen_i,
    input  logic [4:0]  ex_waddr_i,
    input  logic [31:0] ex_wdata_i,
    input  logic        ex_mem_to_reg_i,
    input  logic        mem_wen_i,
    input  logic [4:0]  mem_waddr_i,
    input  logic [31:0] mem_wdata_i,
    output logic        load_use_stall_o,
    output logic        branch_taken_o,
    output logic [31:0] branch_target_o,
    output logic [31:0] ex_pc_o,
    output alu_op_t     ex_alu_op_o,
    output logic [31:0] ex_src_a_o,
    output logic [31:0] ex_src_b_o,
    output logic [31:0] ex_store_data_o,
    output logic        ex_wen_o,
    output logic [4:0]  ex_waddr_o,
    output logic        ex_mem_read_o,
    output logic        ex_mem_write_o
);

    logic [4:0]  rs, rt;
    logic [15:0] imm;
    alu_op_t     alu_op;
    logic        wen, use_rs, use_rt, use_imm, imm_zext, is_shift;
    logic        mem_read, mem_write, is_beq, is_bne;
    logic [4:0]  waddr;
    logic [31:0] rs_val, rt_val, imm_ext, src_a, src_b;

    assign rs  = id_inst_i.r.rs;
    assign rt  = id_inst_i.r.rt;
    assign imm = id_inst_i.i.imm16;

    always_comb begin
        alu_op    = `MIPS_ALU_ADD;
        wen       = 1'b0;
        waddr     = rt;
        use_rs    = 1'b0;
        use_rt    = 1'b0;
        use_imm   = 1'b0;
        imm_zext  = 1'b0;
        is_shift  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        case (id_inst_i.i.op)
            `MIPS_OP_SPECIAL: begin
                waddr  = id_inst_i.r.rd;
                wen    = 1'b1;
                use_rs = 1'b1;
                use_rt = 1'b1;
                case (id_inst_i.r.funct)
                    `MIPS_FUNCT_ADDU: alu_op = `MIPS_ALU_ADD;
                    `MIPS_FUNCT_SUBU: alu_op = `MIPS_ALU_SUB;
                    `MIPS_FUNCT_AND:  alu_op = `MIPS_ALU_AND;
                    `MIPS_FUNCT_OR:   alu_op = `MIPS_ALU_OR;
                    `MIPS_FUNCT_XOR:  alu_op = `MIPS_ALU_XOR;
                    `MIPS_FUNCT_SLT:  alu_op = `MIPS_ALU_SLT;
                    `MIPS_FUNCT_SLL: begin
                        alu_op   = `MIPS_ALU_SLL;
                        use_rs   = 1'b0;
                        is_shift = 1'b1;
                    end
                    default: wen = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: begin
                wen     = 1'b1;
                use_rs  = 1'b1;
                use_imm = 1'b1;
            end
            `MIPS_OP_ORI: begin
                alu_op   = `MIPS_ALU_OR;
                wen      = 1'b1;
                use_rs   = 1'b1;
                use_imm  = 1'b1;
                imm_zext = 1'b1;
            end
            `MIPS_OP_LUI: begin
                alu_op   = `MIPS_ALU_LUI;
                wen      = 1'b1;
                use_imm  = 1'b1;
                imm_zext = 1'b1;
            end
            `MIPS_OP_LW: begin
                wen      = 1'b1;
                use_rs   = 1'b1;
                use_imm  = 1'b1;
                mem_read = 1'b1;
            end
            `MIPS_OP_SW: begin
                use_rs    = 1'b1;
                use_rt    = 1'b1;
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            `MIPS_OP_BEQ: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_beq = 1'b1;
            end
            `MIPS_OP_BNE: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_bne = 1'b1;
            end
            default: ;
        endcase
    end

    // execute result is newer than memory, so it wins
    assign rs_val = (ex_wen_i && rs != 5'd0 && ex_waddr_i == rs) ? ex_wdata_i :
                    (mem_wen_i && rs != 5'd0 && mem_waddr_i == rs) ? mem_wdata_i : rs_data_i;
    assign rt_val = (ex_wen_i && rt != 5'd0 && ex_waddr_i == rt) ? ex_wdata_i :
                    (mem_wen_i && rt != 5'd0 && mem_waddr_i == rt) ? mem_wdata_i : rt_data_i;

    assign load_use_stall_o = id_valid_i && ex_wen_i && ex_mem_to_reg_i && ex_waddr_i != 5'd0
                              && ((use_rs && ex_waddr_i == rs) || (use_rt && ex_waddr_i == rt));

    assign branch_taken_o  = id_valid_i && ((is_beq && rs_val == rt_val)
                                            || (is_bne && rs_val != rt_val));
    assign branch_target_o = id_pc_i + 32'd4 + {{14{imm[15]}}, imm, 2'b00};

    assign imm_ext = imm_zext ? {16'd0, imm} : {{16{imm[15]}}, imm};
    assign src_a   = is_shift ? rt_val : rs_val;
    assign src_b   = is_shift ? {27'd0, id_inst_i.r.shamt} : (use_imm ? imm_ext : rt_val);

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            ex_wen_o       <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
        end else if (!freeze_i) begin
            // bubble on a stall or an empty slot
            ex_wen_o       <= wen & id_valid_i & ~load_use_stall_o;
            ex_mem_read_o  <= mem_read & id_valid_i & ~load_use_stall_o;
            ex_mem_write_o <= mem_write & id_valid_i & ~load_use_stall_o;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!freeze_i) begin
            ex_pc_o         <= id_pc_i;
            ex_alu_op_o     <= alu_op;
            ex_src_a_o      <= src_a;
            ex_src_b_o      <= src_b;
            ex_store_data_o <= rt_val;
            ex_waddr_o      <= waddr;
        end
    end

endmodule

/* verilog/execute_stage.sv */
`include "mips_consts.svh"

module execute_stage
    import mips_pkg::*;
(
    input  logic        clock_i,
    input  logic        reset_i,
    input  logic        freeze_i,
    input  logic [31:0] ex_pc_i,
    input  alu_op_t     ex_alu_op_i,
    input  logic [31:0] ex_src_a_i,
    input  logic [31:0] ex_src_b_i,
    input  logic [31:0] ex_store_data_i,
    input  logic        ex_wen_i,
    input  logic [4:0]  ex_waddr_i,
    input  logic        ex_mem_read_i,
    input  logic        ex_mem_write_i,
    output logic        fwd_wen_o,
    output logic [4:0]  fwd_waddr_o,
    output logic [31:0] fwd_wdata_o,
    output logic        fwd_mem_to_reg_o,
    output logic [31:0] mem_pc_o,
    output logic [31:0] mem_result_o,
    output logic [31:0] mem_store_data_o,
    output logic        mem_wen_o,
    output logic [4:0]  mem_waddr_o,
    output logic        mem_read_o,
    output logic        mem_write_o
);

    logic [31:0] result;

    // loads and stores use the add path for the address
    always_comb begin
        case (ex_alu_op_i)
            `MIPS_ALU_SUB: result = ex_src_a_i - ex_src_b_i;
            `MIPS_ALU_AND: result = ex_src_a_i & ex_src_b_i;
            `MIPS_ALU_OR:  result = ex_src_a_i | ex_src_b_i;
            `MIPS_ALU_XOR: result = ex_src_a_i ^ ex_src_b_i;
            `MIPS_ALU_SLT: result = {31'd0, $signed(ex_src_a_i) < $signed(ex_src_b_i)};
            `MIPS_ALU_SLL: result = ex_src_a_i << ex_src_b_i[4:0];
            `MIPS_ALU_LUI: result = {ex_src_b_i[15:0], 16'd0};
            default:       result = ex_src_a_i + ex_src_b_i;
        endcase
    end

    assign fwd_wen_o        = ex_wen_i;
    assign fwd_waddr_o      = ex_waddr_i;
    assign fwd_wdata_o      = result;
    assign fwd_mem_to_reg_o = ex_mem_read_i;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            mem_wen_o   <= 1'b0;
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
        end else if (!freeze_i) begin
            mem_wen_o   <= ex_wen_i;
            mem_read_o  <= ex_mem_read_i;
            mem_write_o <= ex_mem_write_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!freeze_i) begin
            mem_pc_o         <= ex_pc_i;
            mem_result_o     <= result;
            mem_store_data_o <= ex_store_data_i;
            mem_waddr_o      <= ex_waddr_i;
        end
    end

endmodule

/* verilog/fetch_stage.sv */
`include "mips_consts.svh"

module fetch_stage
    import mips_pkg::*;
(
    input  logic        clock_i,
    input  logic        reset_i,
    input  logic        freeze_i,
    input  logic        load_use_stall_i,
    input  logic        branch_taken_i,
    input  logic [31:0] branch_target_i,
    input  logic [31:0] inst_rdata_i,
    output logic [31:0] inst_addr_o,
    output logic        inst_ren_o,
    output logic [31:0] id_pc_o,
    output mips_inst_u  id_inst_o,
    output logic        id_valid_o
);

    logic        hold;
    logic        running;
    logic [31:0] pc;
    logic        hold_valid;
    mips_inst_u  hold_inst;

    assign hold        = freeze_i | load_use_stall_i;
    assign inst_addr_o = pc;
    assign inst_ren_o  = running & ~hold;

    // the sram word is only live one cycle, keep it while decode waits
    assign id_inst_o = hold_valid ? hold_inst : mips_inst_u'(inst_rdata_i);

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            pc         <= `MIPS_RESET_PC;
            running    <= 1'b0;
            id_valid_o <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (!hold) begin
                id_valid_o <= running;
                hold_valid <= 1'b0;
                // word in flight is the delay slot, so redirect only the next one
                if (running) begin
                    pc <= branch_taken_i ? branch_target_i : pc + 32'd4;
                end
            end else begin
                hold_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (!hold) begin
            id_pc_o <= pc;
        end
        if (hold && !hold_valid) begin
            hold_inst <= mips_inst_u'(inst_rdata_i);
        end
    end

endmodule

/* verilog/memory_stage.sv */
module memory_stage (
    input  logic        clock_i,
    input  logic        reset_i,
    input  logic        freeze_i,
    input  logic [31:0] mem_pc_i,
    input  logic [31:0] mem_result_i,
    input  logic [31:0] mem_store_data_i,
    input  logic        mem_wen_i,
    input  logic [4:0]  mem_waddr_i,
    input  logic        mem_read_i,
    input  logic        mem_write_i,
    input  logic [31:0] data_rdata_i,
    output logic        data_ren_o,
    output logic [3:0]  data_wen_o,
    output logic [31:0] data_addr_o,
    output logic [31:0] data_wdata_o,
    output logic        fwd_wen_o,
    output logic [4:0]  fwd_waddr_o,
    output logic [31:0] fwd_wdata_o,
    output logic [31:0] wb_pc_o,
    output logic        wb_wen_o,
    output logic [4:0]  wb_waddr_o,
    output logic [31:0] wb_wdata_o
);

    logic [31:0] wdata;

    assign data_ren_o   = mem_read_i;
    // store goes out once, on the first unfrozen cycle
    assign data_wen_o   = (mem_write_i && !freeze_i) ? 4'b1111 : 4'b0000;
    assign data_addr_o  = mem_result_i;
    assign data_wdata_o = mem_store_data_i;

    // sram read is combinational, load data is ready here
    assign wdata = mem_read_i ? data_rdata_i : mem_result_i;

    assign fwd_wen_o   = mem_wen_i;
    assign fwd_waddr_o = mem_waddr_i;
    assign fwd_wdata_o = wdata;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            wb_wen_o <= 1'b0;
        end else if (!freeze_i) begin
            wb_wen_o <= mem_wen_i && mem_waddr_i != 5'd0;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!freeze_i) begin
            wb_pc_o    <= mem_pc_i;
            wb_waddr_o <= mem_waddr_i;
            wb_wdata_o <= wdata;
        end
    end

endmodule

/* verilog/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// first fetch after reset
`define MIPS_RESET_PC     32'hbfc00000

// primary opcodes
`define MIPS_OP_SPECIAL   6'b000000
`define MIPS_OP_BEQ       6'b000100
`define MIPS_OP_BNE       6'b000101
`define MIPS_OP_ADDIU     6'b001001
`define MIPS_OP_ORI       6'b001101
`define MIPS_OP_LUI       6'b001111
`define MIPS_OP_LW        6'b100011
`define MIPS_OP_SW        6'b101011

// funct field of SPECIAL
`define MIPS_FUNCT_SLL    6'b000000
`define MIPS_FUNCT_ADDU   6'b100001
`define MIPS_FUNCT_SUBU   6'b100011
`define MIPS_FUNCT_AND    6'b100100
`define MIPS_FUNCT_OR     6'b100101
`define MIPS_FUNCT_XOR    6'b100110
`define MIPS_FUNCT_SLT    6'b101010

// alu operations
`define MIPS_ALU_ADD      4'd0
`define MIPS_ALU_SUB      4'd1
`define MIPS_ALU_AND      4'd2
`define MIPS_ALU_OR       4'd3
`define MIPS_ALU_XOR      4'd4
`define MIPS_ALU_SLT      4'd5
`define MIPS_ALU_SLL      4'd6
`define MIPS_ALU_LUI      4'd7

`endif

/* verilog/mips_pkg.sv */
package mips_pkg;

    // register format
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } inst_r_t;

    // immediate format
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } inst_i_t;

    // one fetched word, read through either format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } mips_inst_u;

    typedef logic [3:0] alu_op_t;

endpackage

/* verilog/mips_top.sv */
module mips_top
    import mips_pkg::*;
(
    input  logic        clock_i,
    input  logic        reset_i,

    output logic [31:0] inst_sram_addr_o,
    output logic        inst_sram_ren_o,
    input  logic [31:0] inst_sram_rdata_i,

    output logic        data_sram_ren_o,
    output logic [3:0]  data_sram_wen_o,
    output logic [31:0] data_sram_addr_o,
    output logic [31:0] data_sram_wdata_o,
    input  logic [31:0] data_sram_rdata_i,

    input  logic        data_stall_i,

    output logic [31:0] debug_wb_pc_o,
    output logic [3:0]  debug_wb_wen_o,
    output logic [4:0]  debug_wb_num_o,
    output logic [31:0] debug_wb_data_o
);

    logic        load_use_stall, branch_taken;
    logic [31:0] branch_target;

    logic [31:0] id_pc;
    mips_inst_u  id_inst;
    logic        id_valid;
    logic [31:0] rs_data, rt_data;

    logic [31:0] ex_pc, ex_src_a, ex_src_b, ex_store_data;
    alu_op_t     ex_alu_op;
    logic        ex_wen, ex_mem_read, ex_mem_write;
    logic [4:0]  ex_waddr;

    logic        ex_fwd_wen, ex_fwd_mem_to_reg;
    logic [4:0]  ex_fwd_waddr;
    logic [31:0] ex_fwd_wdata;

    logic [31:0] mem_pc, mem_result, mem_store_data;
    logic        mem_wen, mem_read, mem_write;
    logic [4:0]  mem_waddr;

    logic        mem_fwd_wen;
    logic [4:0]  mem_fwd_waddr;
    logic [31:0] mem_fwd_wdata;

    logic        wb_wen, wb_commit;
    logic [4:0]  wb_waddr;
    logic [31:0] wb_wdata;

    // writeback register holds under freeze, so retire only once
    assign wb_commit       = wb_wen & ~data_stall_i;
    assign debug_wb_wen_o  = {4{wb_commit}};
    assign debug_wb_num_o  = wb_waddr;
    assign debug_wb_data_o = wb_wdata;

    fetch_stage u_fetch (
        .clock_i         (clock_i),
        .reset_i         (reset_i),
        .freeze_i        (data_stall_i),
        .load_use_stall_i(load_use_stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .inst_rdata_i    (inst_sram_rdata_i),
        .inst_addr_o     (inst_sram_addr_o),
        .inst_ren_o      (inst_sram_ren_o),
        .id_pc_o         (id_pc),
        .id_inst_o       (id_inst),
        .id_valid_o      (id_valid)
    );

    regfile u_regfile (
        .clock_i  (clock_i),
        .reset_i  (reset_i),
        .we_i     (wb_commit),
        .waddr_i  (wb_waddr),
        .wdata_i  (wb_wdata),
        .raddr_a_i(id_inst.r.rs),
        .raddr_b_i(id_inst.r.rt),
        .rdata_a_o(rs_data),
        .rdata_b_o(rt_data)
    );

    decode_stage u_decode (
        .clock_i         (clock_i),
        .reset_i         (reset_i),
        .freeze_i        (data_stall_i),
        .id_pc_i         (id_pc),
        .id_inst_i       (id_inst),
        .id_valid_i      (id_valid),
        .rs_data_i       (rs_data),
        .rt_data_i       (rt_data),
        .ex_wen_i        (ex_fwd_wen),
        .ex_waddr_i      (ex_fwd_waddr),
        .ex_wdata_i      (ex_fwd_wdata),
        .ex_mem_to_reg_i (ex_fwd_mem_to_reg),
        .mem_wen_i       (mem_fwd_wen),
        .mem_waddr_i     (mem_fwd_waddr),
        .mem_wdata_i     (mem_fwd_wdata),
        .load_use_stall_o(load_use_stall),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_pc_o         (ex_pc),
        .ex_alu_op_o     (ex_alu_op),
        .ex_src_a_o      (ex_src_a),
        .ex_src_b_o      (ex_src_b),
        .ex_store_data_o (ex_store_data),
        .ex_wen_o        (ex_wen),
        .ex_waddr_o      (ex_waddr),
        .ex_mem_read_o   (ex_mem_read),
        .ex_mem_write_o  (ex_mem_write)
    );

    execute_stage u_execute (
        .clock_i         (clock_i),
        .reset_i         (reset_i),
        .freeze_i        (data_stall_i),
        .ex_pc_i         (ex_pc),
        .ex_alu_op_i     (ex_alu_op),
        .ex_src_a_i      (ex_src_a),
        .ex_src_b_i      (ex_src_b),
        .ex_store_data_i (ex_store_data),
        .ex_wen_i        (ex_wen),
        .ex_waddr_i      (ex_waddr),
        .ex_mem_read_i   (ex_mem_read),
        .ex_mem_write_i  (ex_mem_write),
        .fwd_wen_o       (ex_fwd_wen),
        .fwd_waddr_o     (ex_fwd_waddr),
        .fwd_wdata_o     (ex_fwd_wdata),
        .fwd_mem_to_reg_o(ex_fwd_mem_to_reg),
        .mem_pc_o        (mem_pc),
        .mem_result_o    (mem_result),
        .mem_store_data_o(mem_store_data),
        .mem_wen_o       (mem_wen),
        .mem_waddr_o     (mem_waddr),
        .mem_read_o      (mem_read),
        .mem_write_o     (mem_write)
    );

    memory_stage u_memory (
        .clock_i         (clock_i),
        .reset_i         (reset_i),
        .freeze_i        (data_stall_i),
        .mem_pc_i        (mem_pc),
        .mem_result_i    (mem_result),
        .mem_store_data_i(mem_store_data),
        .mem_wen_i       (mem_wen),
        .mem_waddr_i     (mem_waddr),
        .mem_read_i      (mem_read),
        .mem_write_i     (mem_write),
        .data_rdata_i    (data_sram_rdata_i),
        .data_ren_o      (data_sram_ren_o),
        .data_wen_o      (data_sram_wen_o),
        .data_addr_o     (data_sram_addr_o),
        .data_wdata_o    (data_sram_wdata_o),
        .fwd_wen_o       (mem_fwd_wen),
        .fwd_waddr_o     (mem_fwd_waddr),
        .fwd_wdata_o     (mem_fwd_wdata),
        .wb_pc_o         (debug_wb_pc_o),
        .wb_wen_o        (wb_wen),
        .wb_waddr_o      (wb_waddr),
        .wb_wdata_o      (wb_wdata)
    );

endmodule

/* verilog/regfile.sv */
module regfile (
    input  logic        clock_i,
    input  logic        reset_i,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    input  logic [4:0]  raddr_a_i,
    input  logic [4:0]  raddr_b_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            regs <= '{default: 32'd0};
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 reads zero, a same-cycle write is passed straight through
    assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 :
                       (we_i && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 :
                       (we_i && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule
